// ==== include/msi_consts.svh ====
// MSI generator constants
`ifndef MSI_CONSTS_SVH
`define MSI_CONSTS_SVH

// Interrupt lines and destination table
`define MSI_NUM_IRQ 4
`define MSI_NUM_DEST 2

// Bus widths
`define MSI_ADDR_W 32
`define MSI_DATA_W 32

// Device ID goes into address bits above the word offset
`define MSI_DEVID_W 16
`define MSI_EVTID_W 16

// Throttle counter
`define MSI_THR_W 8

// Selects one of MSI_NUM_DEST base addresses
`define MSI_DEST_IDX_W 1

`endif

// ==== src/msi_cfg_pkg.sv ====
// MSI configuration types
`include "msi_consts.svh"

package msi_cfg_pkg;

  // Address and data words of the message write
  typedef logic [`MSI_ADDR_W-1:0] addr_t;
  typedef logic [`MSI_DATA_W-1:0] data_t;

  // Per-interrupt payload fields
  typedef logic [`MSI_DEVID_W-1:0] device_id_t;
  typedef logic [`MSI_EVTID_W-1:0] event_id_t;
  typedef logic [`MSI_DEST_IDX_W-1:0] dest_idx_t;

  // Minimum spacing between writes
  typedef logic [`MSI_THR_W-1:0] throttle_cnt_t;

  // One bit per interrupt line
  typedef logic [`MSI_NUM_IRQ-1:0] irq_vec_t;

endpackage

// ==== src/axil_pkg.sv ====
// AXI4-Lite write types
`include "msi_consts.svh"

package axil_pkg;

  typedef logic [1:0] resp_t;
  typedef logic [`MSI_DATA_W/8-1:0] strb_t;

  localparam resp_t resp_okay = 2'b00;

  // Write initiator FSM
  typedef enum logic [1:0] {
    W_IDLE,
    W_ADDR_DATA,
    W_RESP,
    W_THROTTLE
  } wr_state_e;

endpackage

// ==== src/msi_req_if.sv ====
// MSI request and write interfaces
`timescale 1ns/1ps

// One pending request from a vector towards the arbiter
interface msi_req_if;
  logic                   pending;
  msi_cfg_pkg::device_id_t device_id;
  msi_cfg_pkg::event_id_t  event_id;
  msi_cfg_pkg::dest_idx_t  dest_idx;
  logic                   grant;

  modport vector (output pending, device_id, event_id, dest_idx, input grant);
  modport arbiter (input pending, device_id, event_id, dest_idx, output grant);
endinterface

// Formed message from the arbiter to the AXI writer
interface msi_wr_if;
  logic               start;
  msi_cfg_pkg::addr_t addr;
  msi_cfg_pkg::data_t data;
  logic               idle;

  modport arbiter (output start, addr, data, input idle);
  modport writer (input start, addr, data, output idle);
endinterface

// ==== src/msi_irq_capture.sv ====
// Interrupt edge capture
`timescale 1ns/1ps

module msi_irq_capture (
  input  logic                  clk,
  input  logic                  rst,
  input  msi_cfg_pkg::irq_vec_t irq,
  input  msi_cfg_pkg::irq_vec_t msi_enable,
  output msi_cfg_pkg::irq_vec_t edge_pulse
);

  // Sampled lines and their values one cycle earlier
  msi_cfg_pkg::irq_vec_t irq_q;
  msi_cfg_pkg::irq_vec_t irq_prev_q;
  msi_cfg_pkg::irq_vec_t rise;

  // Rise seen between the two samples, masked by enable
  assign rise = irq_q & ~irq_prev_q & msi_enable;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      irq_q      <= '0;
      irq_prev_q <= '0;
      edge_pulse <= '0;
    end else begin
      irq_q      <= irq;
      irq_prev_q <= irq_q;
      // Single cycle since irq_prev_q catches up next edge
      edge_pulse <= rise;
    end
  end

endmodule

// ==== src/msi_vector.sv ====
// Per-interrupt pending vector
`timescale 1ns/1ps

module msi_vector (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    set_pulse,
  input  msi_cfg_pkg::device_id_t device_id,
  input  msi_cfg_pkg::event_id_t  event_id,
  input  msi_cfg_pkg::dest_idx_t  dest_idx,
  msi_req_if.vector               req
);

  logic                    pending_q;
  logic                    take_new;
  msi_cfg_pkg::device_id_t device_id_q;
  msi_cfg_pkg::event_id_t  event_id_q;
  msi_cfg_pkg::dest_idx_t  dest_idx_q;

  // A repeat edge while still pending merges into the queued message
  assign take_new = set_pulse && (!pending_q || req.grant);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pending_q <= 1'b0;
    end else begin
      // New pulse wins over a grant in the same cycle
      pending_q <= set_pulse || (pending_q && !req.grant);
    end
  end

  // Snapshot of the configuration at request time
  always_ff @(posedge clk) begin
    if (take_new) begin
      device_id_q <= device_id;
      event_id_q  <= event_id;
      dest_idx_q  <= dest_idx;
    end
  end

  assign req.pending   = pending_q;
  assign req.device_id = device_id_q;
  assign req.event_id  = event_id_q;
  assign req.dest_idx  = dest_idx_q;

endmodule

// ==== src/msi_arbiter.sv ====
// Round-robin MSI arbiter
`timescale 1ns/1ps
`include "msi_consts.svh"

module msi_arbiter (
  input  logic                                      clk,
  input  logic                                      rst,
  msi_req_if.arbiter                                req [`MSI_NUM_IRQ],
  input  msi_cfg_pkg::addr_t [`MSI_NUM_DEST-1:0]    msi_dest_addr,
  msi_wr_if.arbiter                                 wr
);

  localparam int idx_w = $clog2(`MSI_NUM_IRQ);

  msi_cfg_pkg::irq_vec_t   pend;
  msi_cfg_pkg::irq_vec_t   grant_vec;
  msi_cfg_pkg::device_id_t dev_id [`MSI_NUM_IRQ];
  msi_cfg_pkg::event_id_t  evt_id [`MSI_NUM_IRQ];
  msi_cfg_pkg::dest_idx_t  dst_idx [`MSI_NUM_IRQ];
  logic [idx_w-1:0]        last_q;
  logic [idx_w-1:0]        sel;
  logic [idx_w-1:0]        cand;
  logic                    found;

  // Flatten the interface array so it can be indexed at run time
  for (genvar i = 0; i < `MSI_NUM_IRQ; i++) begin : g_unpack
    assign pend[i]      = req[i].pending;
    assign dev_id[i]    = req[i].device_id;
    assign evt_id[i]    = req[i].event_id;
    assign dst_idx[i]   = req[i].dest_idx;
    assign req[i].grant = grant_vec[i];
  end

  // First pending line after the last one granted
  always_comb begin
    sel   = last_q;
    found = 1'b0;
    cand  = last_q;
    for (int off = 1; off <= `MSI_NUM_IRQ; off++) begin
      cand = idx_w'((int'(last_q) + off) % `MSI_NUM_IRQ);
      if (!found && pend[cand]) begin
        sel   = cand;
        found = 1'b1;
      end
    end
  end

  assign wr.start = wr.idle && found;

  always_comb begin
    grant_vec = '0;
    if (wr.start) begin
      grant_vec[sel] = 1'b1;
    end
  end

  // Device ID lands above the 32-bit word offset
  assign wr.addr = msi_dest_addr[dst_idx[sel]] + (msi_cfg_pkg::addr_t'(dev_id[sel]) << 2);
  assign wr.data = msi_cfg_pkg::data_t'(evt_id[sel]);

  // Start just below line 0 so it has first priority after reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      last_q <= idx_w'(`MSI_NUM_IRQ - 1);
    end else if (wr.start) begin
      last_q <= sel;
    end
  end

endmodule

// ==== src/msi_axil_writer.sv ====
// AXI4-Lite MSI write initiator
`timescale 1ns/1ps

module msi_axil_writer (
  input  logic                       clk,
  input  logic                       rst,
  msi_wr_if.writer                   wr,
  input  logic                       throttle_en,
  input  msi_cfg_pkg::throttle_cnt_t throttle_cntr_threshold,
  output msi_cfg_pkg::addr_t         awaddr,
  output logic                       awvalid,
  input  logic                       awready,
  output msi_cfg_pkg::data_t         wdata,
  output axil_pkg::strb_t            wstrb,
  output logic                       wvalid,
  input  logic                       wready,
  input  axil_pkg::resp_t            bresp,
  input  logic                       bvalid,
  output logic                       bready,
  output logic                       error
);

  axil_pkg::wr_state_e        state_q;
  axil_pkg::wr_state_e        state_d;
  msi_cfg_pkg::throttle_cnt_t thr_cnt_q;
  msi_cfg_pkg::addr_t         addr_q;
  msi_cfg_pkg::data_t         data_q;
  logic                       aw_pend_q;
  logic                       w_pend_q;
  logic                       aw_ok;
  logic                       w_ok;
  logic                       thr_busy;

  // Each channel is done once its own handshake has happened
  assign aw_ok = !aw_pend_q || awready;
  assign w_ok  = !w_pend_q || wready;

  // Leave throttle one cycle early so the next awvalid rise lands on the threshold
  assign thr_busy = throttle_en && (thr_cnt_q > msi_cfg_pkg::throttle_cnt_t'(1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      axil_pkg::W_IDLE:      if (wr.start) state_d = axil_pkg::W_ADDR_DATA;
      axil_pkg::W_ADDR_DATA: if (aw_ok && w_ok) state_d = axil_pkg::W_RESP;
      axil_pkg::W_RESP: begin
        if (bvalid) state_d = thr_busy ? axil_pkg::W_THROTTLE : axil_pkg::W_IDLE;
      end
      axil_pkg::W_THROTTLE:  if (!thr_busy) state_d = axil_pkg::W_IDLE;
      default:               state_d = axil_pkg::W_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q   <= axil_pkg::W_IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      thr_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (wr.start) begin
        aw_pend_q <= 1'b1;
        w_pend_q  <= 1'b1;
        // Loaded on the awvalid rise and a zero threshold means no spacing
        if (throttle_en && (throttle_cntr_threshold != '0)) begin
          thr_cnt_q <= throttle_cntr_threshold - msi_cfg_pkg::throttle_cnt_t'(1);
        end else begin
          thr_cnt_q <= '0;
        end
      end else begin
        if (awready) aw_pend_q <= 1'b0;
        if (wready) w_pend_q <= 1'b0;
        if (thr_cnt_q != '0) thr_cnt_q <= thr_cnt_q - msi_cfg_pkg::throttle_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr.start) begin
      addr_q <= wr.addr;
      data_q <= wr.data;
    end
  end

  assign awaddr  = addr_q;
  assign awvalid = aw_pend_q;
  assign wdata   = data_q;
  assign wvalid  = w_pend_q;
  // Event ID always fits in the low four bytes
  assign wstrb   = '1;
  assign bready  = (state_q == axil_pkg::W_RESP);
  assign error   = bready && bvalid && (bresp != axil_pkg::resp_okay);
  assign wr.idle = (state_q == axil_pkg::W_IDLE);

endmodule

// ==== src/msi_gen_top.sv ====
// AXI4-Lite MSI generator top
`timescale 1ns/1ps
`include "msi_consts.svh"

module msi_gen_top (
  input  logic                                       clk,
  input  logic                                       rst,
  input  msi_cfg_pkg::irq_vec_t                      irq,
  input  msi_cfg_pkg::irq_vec_t                      msi_enable,
  input  msi_cfg_pkg::dest_idx_t  [`MSI_NUM_IRQ-1:0] msi_dest_idx,
  input  msi_cfg_pkg::device_id_t [`MSI_NUM_IRQ-1:0] device_id_per_irq,
  input  msi_cfg_pkg::event_id_t  [`MSI_NUM_IRQ-1:0] event_id_per_irq,
  input  msi_cfg_pkg::addr_t     [`MSI_NUM_DEST-1:0] msi_dest_addr,
  input  logic                                       throttle_en,
  input  msi_cfg_pkg::throttle_cnt_t                 throttle_cntr_threshold,
  output logic                                       error,
  output msi_cfg_pkg::addr_t                         awaddr,
  output logic                                       awvalid,
  input  logic                                       awready,
  output msi_cfg_pkg::data_t                         wdata,
  output axil_pkg::strb_t                            wstrb,
  output logic                                       wvalid,
  input  logic                                       wready,
  input  axil_pkg::resp_t                            bresp,
  input  logic                                       bvalid,
  output logic                                       bready
);

  msi_cfg_pkg::irq_vec_t edge_pulse;

  msi_req_if req_if [`MSI_NUM_IRQ] ();
  msi_wr_if  wr_if ();

  msi_irq_capture u_capture (
    .clk        (clk),
    .rst        (rst),
    .irq        (irq),
    .msi_enable (msi_enable),
    .edge_pulse (edge_pulse)
  );

  for (genvar i = 0; i < `MSI_NUM_IRQ; i++) begin : g_vec
    msi_vector u_vector (
      .clk       (clk),
      .rst       (rst),
      .set_pulse (edge_pulse[i]),
      .device_id (device_id_per_irq[i]),
      .event_id  (event_id_per_irq[i]),
      .dest_idx  (msi_dest_idx[i]),
      .req       (req_if[i])
    );
  end

  msi_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .req           (req_if),
    .msi_dest_addr (msi_dest_addr),
    .wr            (wr_if)
  );

  msi_axil_writer u_writer (
    .clk                     (clk),
    .rst                     (rst),
    .wr                      (wr_if),
    .throttle_en             (throttle_en),
    .throttle_cntr_threshold (throttle_cntr_threshold),
    .awaddr                  (awaddr),
    .awvalid                 (awvalid),
    .awready                 (awready),
    .wdata                   (wdata),
    .wstrb                   (wstrb),
    .wvalid                  (wvalid),
    .wready                  (wready),
    .bresp                   (bresp),
    .bvalid                  (bvalid),
    .bready                  (bready),
    .error                   (error)
  );

endmodule

// ==== verif/msi_gen_tb.sv ====
// MSI generator testbench
`timescale 1ns/1ps
`include "msi_consts.svh"

module msi_gen_tb;

  logic                                       clk;
  logic                                       rst;
  msi_cfg_pkg::irq_vec_t                      irq;
  msi_cfg_pkg::irq_vec_t                      msi_enable;
  msi_cfg_pkg::dest_idx_t  [`MSI_NUM_IRQ-1:0] msi_dest_idx;
  msi_cfg_pkg::device_id_t [`MSI_NUM_IRQ-1:0] device_id_per_irq;
  msi_cfg_pkg::event_id_t  [`MSI_NUM_IRQ-1:0] event_id_per_irq;
  msi_cfg_pkg::addr_t     [`MSI_NUM_DEST-1:0] msi_dest_addr;
  logic                                       throttle_en;
  msi_cfg_pkg::throttle_cnt_t                 throttle_cntr_threshold;
  logic                                       error;
  msi_cfg_pkg::addr_t                         awaddr;
  logic                                       awvalid;
  logic                                       awready;
  msi_cfg_pkg::data_t                         wdata;
  axil_pkg::strb_t                            wstrb;
  logic                                       wvalid;
  logic                                       wready;
  axil_pkg::resp_t                            bresp;
  logic                                       bvalid;
  logic                                       bready;

  // Random streams, target state and scoreboard
  logic [31:0]        stim_rng;
  logic [31:0]        resp_rng;
  int                 stall_cycles;
  logic               slverr_mode;
  int                 aw_wait;
  int                 w_wait;
  int                 b_wait;
  string              cur_test;
  int                 errors;
  int                 errors_at_start;
  int                 tests_run;
  int                 tests_failed;
  int                 err_pulses;
  int                 last_grant;
  int                 cycle;
  int                 last_rise;
  logic               have_rise;
  logic               thr_check;
  logic               awvalid_prev;
  logic               aw_hold;
  logic               w_hold;
  msi_cfg_pkg::addr_t hold_addr;
  msi_cfg_pkg::data_t hold_data;
  msi_cfg_pkg::addr_t aw_seen;
  msi_cfg_pkg::data_t w_seen;
  axil_pkg::strb_t    strb_seen;
  msi_cfg_pkg::addr_t exp_addr [$];
  msi_cfg_pkg::data_t exp_data [$];
  msi_cfg_pkg::addr_t obs_addr [$];
  msi_cfg_pkg::data_t obs_data [$];
  axil_pkg::strb_t    obs_strb [$];

  msi_gen_top uut (
    .clk                     (clk),
    .rst                     (rst),
    .irq                     (irq),
    .msi_enable              (msi_enable),
    .msi_dest_idx            (msi_dest_idx),
    .device_id_per_irq       (device_id_per_irq),
    .event_id_per_irq        (event_id_per_irq),
    .msi_dest_addr           (msi_dest_addr),
    .throttle_en             (throttle_en),
    .throttle_cntr_threshold (throttle_cntr_threshold),
    .error                   (error),
    .awaddr                  (awaddr),
    .awvalid                 (awvalid),
    .awready                 (awready),
    .wdata                   (wdata),
    .wstrb                   (wstrb),
    .wvalid                  (wvalid),
    .wready                  (wready),
    .bresp                   (bresp),
    .bvalid                  (bvalid),
    .bready                  (bready)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_rng = lcg_step(stim_rng);
    return stim_rng;
  endfunction

  // AXI target raises ready and response after 0 to 3 cycles plus any forced stall
  always @(negedge clk) begin
    if (!awvalid) begin
      resp_rng = lcg_step(resp_rng);
      aw_wait  = resp_rng[17:16] + stall_cycles;
      awready  = 1'b0;
    end else if (!awready) begin
      if (aw_wait == 0) awready = 1'b1;
      else aw_wait = aw_wait - 1;
    end
    if (!wvalid) begin
      resp_rng = lcg_step(resp_rng);
      w_wait   = resp_rng[19:18] + stall_cycles;
      wready   = 1'b0;
    end else if (!wready) begin
      if (w_wait == 0) wready = 1'b1;
      else w_wait = w_wait - 1;
    end
    if (!bready) begin
      resp_rng = lcg_step(resp_rng);
      b_wait   = resp_rng[21:20];
      bvalid   = 1'b0;
      bresp    = 2'b00;
    end else if (!bvalid) begin
      if (b_wait == 0) begin
        bvalid = 1'b1;
        bresp  = slverr_mode ? 2'b10 : 2'b00;
      end else begin
        b_wait = b_wait - 1;
      end
    end
  end

  // Bus monitor samples the values that were stable through the cycle
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (!rst) begin
      if (awvalid && !awvalid_prev) begin
        if (!wvalid) begin
          $display("%s: awvalid rose without wvalid", cur_test);
          errors++;
        end
        if (thr_check && have_rise && (cycle - last_rise) < int'(throttle_cntr_threshold)) begin
          $display("mismatch %s spacing expected at least %0d actual %0d",
                   cur_test, throttle_cntr_threshold, cycle - last_rise);
          errors++;
        end
        last_rise = cycle;
        have_rise = 1'b1;
      end
      if (aw_hold && awvalid && awaddr != hold_addr) begin
        $display("mismatch %s held awaddr expected %h actual %h", cur_test, hold_addr, awaddr);
        errors++;
      end
      if (w_hold && wvalid && wdata != hold_data) begin
        $display("mismatch %s held wdata expected %h actual %h", cur_test, hold_data, wdata);
        errors++;
      end
      aw_hold   = awvalid && !awready;
      w_hold    = wvalid && !wready;
      hold_addr = awaddr;
      hold_data = wdata;
      if (awvalid && awready) aw_seen = awaddr;
      if (wvalid && wready) begin
        w_seen    = wdata;
        strb_seen = wstrb;
      end
      if (bvalid && bready) begin
        obs_addr.push_back(aw_seen);
        obs_data.push_back(w_seen);
        obs_strb.push_back(strb_seen);
      end
      if (error) begin
        err_pulses++;
        if (!(bvalid && bready)) begin
          $display("%s: error pulse outside a write response", cur_test);
          errors++;
        end
      end
    end
    awvalid_prev = awvalid;
  end

  task automatic randomize_cfg();
    logic [31:0] r;
    for (int i = 0; i < `MSI_NUM_IRQ; i++) begin
      r = next_stim();
      device_id_per_irq[i] = r[15:0];
      event_id_per_irq[i]  = r[31:16];
      r = next_stim();
      msi_dest_idx[i] = r[24];
    end
    for (int d = 0; d < `MSI_NUM_DEST; d++) begin
      msi_dest_addr[d] = next_stim();
    end
  endtask

  // Expected message is base plus device ID times four and event ID zero-extended
  task automatic expect_line(input int line);
    exp_addr.push_back(msi_dest_addr[msi_dest_idx[line]] + {device_id_per_irq[line], 2'b00});
    exp_data.push_back({16'h0000, event_id_per_irq[line]});
    last_grant = line;
  endtask

  // Pending lines come out in rotating order after the last grant
  task automatic expect_rr(input msi_cfg_pkg::irq_vec_t mask);
    int base;
    base = last_grant;
    for (int k = 1; k <= `MSI_NUM_IRQ; k++) begin
      if (mask[(base + k) % `MSI_NUM_IRQ]) expect_line((base + k) % `MSI_NUM_IRQ);
    end
  endtask

  task automatic fire_irq(input msi_cfg_pkg::irq_vec_t mask);
    irq = mask;
    repeat (2) @(negedge clk);
    irq = '0;
    repeat (2) @(negedge clk);
  endtask

  task automatic wait_writes(input int timeout);
    int n;
    n = 0;
    while (obs_addr.size() < exp_addr.size() && n < timeout) begin
      @(negedge clk);
      n++;
    end
    if (obs_addr.size() < exp_addr.size()) begin
      $display("%s: timed out waiting for %0d writes, saw %0d",
               cur_test, exp_addr.size(), obs_addr.size());
      errors++;
    end
  endtask

  task automatic expect_quiet(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      if (awvalid) begin
        $display("%s: unexpected write on the AXI bus", cur_test);
        errors++;
        break;
      end
    end
  endtask

  task automatic check_writes();
    logic [31:0] ea;
    logic [31:0] ed;
    if (obs_addr.size() != exp_addr.size()) begin
      $display("mismatch %s write count expected %0d actual %0d",
               cur_test, exp_addr.size(), obs_addr.size());
      errors++;
    end
    while (exp_addr.size() > 0 && obs_addr.size() > 0) begin
      ea = exp_addr.pop_front();
      ed = exp_data.pop_front();
      if (obs_addr[0] != ea) begin
        $display("mismatch %s awaddr expected %h actual %h", cur_test, ea, obs_addr[0]);
        errors++;
      end
      if (obs_data[0] != ed) begin
        $display("mismatch %s wdata expected %h actual %h", cur_test, ed, obs_data[0]);
        errors++;
      end
      if (obs_strb[0] != 4'hf) begin
        $display("mismatch %s wstrb expected %h actual %h", cur_test, 4'hf, obs_strb[0]);
        errors++;
      end
      void'(obs_addr.pop_front());
      void'(obs_data.pop_front());
      void'(obs_strb.pop_front());
    end
    exp_addr.delete();
    exp_data.delete();
    obs_addr.delete();
    obs_data.delete();
    obs_strb.delete();
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("%s: fail, %0d errors", cur_test, errors - errors_at_start);
    end else begin
      $display("%s: pass", cur_test);
    end
    errors_at_start = errors;
  endtask

  task automatic single_error_case(input logic slverr, input int pulses);
    logic [31:0] r;
    int line;
    randomize_cfg();
    r           = next_stim();
    line        = r[1:0];
    msi_enable  = '1;
    slverr_mode = slverr;
    err_pulses  = 0;
    fire_irq(msi_cfg_pkg::irq_vec_t'(1 << line));
    expect_line(line);
    wait_writes(100);
    expect_quiet(10);
    check_writes();
    if (err_pulses != pulses) begin
      $display("mismatch %s error pulses expected %0d actual %0d", cur_test, pulses, err_pulses);
      errors++;
    end
    slverr_mode = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    int line;
    irq = '0;
    msi_enable = '0;
    msi_dest_idx = '0;
    device_id_per_irq = '0;
    event_id_per_irq = '0;
    msi_dest_addr = '0;
    throttle_en = 1'b0;
    throttle_cntr_threshold = '0;
    awready = 1'b0;
    wready = 1'b0;
    bresp = 2'b00;
    bvalid = 1'b0;
    stim_rng = 32'hf29d;
    resp_rng = lcg_step(32'hf29d);
    stall_cycles = 0;
    slverr_mode = 1'b0;
    errors = 0;
    errors_at_start = 0;
    tests_run = 0;
    tests_failed = 0;
    err_pulses = 0;
    last_grant = `MSI_NUM_IRQ - 1;
    cycle = 0;
    last_rise = 0;
    have_rise = 1'b0;
    thr_check = 1'b0;
    awvalid_prev = 1'b0;
    aw_hold = 1'b0;
    w_hold = 1'b0;
    rst = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    cur_test = "reset";
    @(negedge clk);
    if (awvalid || wvalid || bready || error) begin
      $display("%s: AXI outputs not idle after reset", cur_test);
      errors++;
    end
    expect_quiet(20);
    check_writes();
    finish_test();

    cur_test = "single";
    repeat (8) begin
      randomize_cfg();
      r = next_stim();
      line = r[1:0];
      msi_enable = r[7:4] | msi_cfg_pkg::irq_vec_t'(1 << line);
      fire_irq(msi_cfg_pkg::irq_vec_t'(1 << line));
      expect_line(line);
      wait_writes(100);
      expect_quiet(10);
      check_writes();
    end
    finish_test();

    cur_test = "disabled";
    repeat (4) begin
      r = next_stim();
      line = r[1:0];
      msi_enable = r[7:4] & ~msi_cfg_pkg::irq_vec_t'(1 << line);
      fire_irq(msi_cfg_pkg::irq_vec_t'(1 << line));
      expect_quiet(30);
      check_writes();
    end
    finish_test();

    cur_test = "simultaneous";
    randomize_cfg();
    msi_enable = '1;
    fire_irq('1);
    expect_rr('1);
    wait_writes(300);
    expect_quiet(10);
    check_writes();
    finish_test();

    // Long ready stalls first and then tight spacing under the throttle
    cur_test = "backpressure_throttle";
    randomize_cfg();
    stall_cycles = 4;
    fire_irq('1);
    expect_rr('1);
    wait_writes(400);
    check_writes();
    stall_cycles = 0;
    r = next_stim();
    throttle_cntr_threshold = 8 + r[3:0];
    throttle_en = 1'b1;
    have_rise = 1'b0;
    thr_check = 1'b1;
    fire_irq('1);
    expect_rr('1);
    wait_writes(400);
    expect_quiet(10);
    check_writes();
    thr_check = 1'b0;
    throttle_en = 1'b0;
    finish_test();

    cur_test = "error_response";
    single_error_case(1'b1, 1);
    single_error_case(1'b0, 0);
    finish_test();

    $display("tests %0d failed %0d errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
src/msi_cfg_pkg.sv
src/axil_pkg.sv
src/msi_req_if.sv
src/msi_irq_capture.sv
src/msi_vector.sv
src/msi_arbiter.sv
src/msi_axil_writer.sv
src/msi_gen_top.sv
verif/msi_gen_tb.sv

// ==== Bender.yml ====
package:
  name: msi_gen

export_include_dirs:
  - include

sources:
  - files:
      - src/msi_cfg_pkg.sv
      - src/axil_pkg.sv
      - src/msi_req_if.sv
      - src/msi_irq_capture.sv
      - src/msi_vector.sv
      - src/msi_arbiter.sv
      - src/msi_axil_writer.sv
      - src/msi_gen_top.sv
  - target: simulation
    files:
      - verif/msi_gen_tb.sv
